/* filelist.f */
+incdir+src
src/rv_pipe_pkg.sv
src/rv_pipe_reg.sv
src/rv_regfile.sv
src/rv_id_stage.sv
src/rv_ex_stage.sv
src/rv_wb_stage.sv
src/rv_core_top.sv
tb/rv_commit_checker.sv
tb/tb_rv_core.sv

/* run.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module tb_rv_core \
  -f filelist.f --Mdir "$build_dir" -o sim_tb_rv_core
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/sim_tb_rv_core" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Done: errors found" "$log"; then
  exit 1
fi
exit 0

/* src/rv_core_top.sv */
// rv core pipeline tail: decode, execute and write-back around the register file
`timescale 1ns/1ps
`include "rv_pipe_params.svh"

module rv_core_top (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_inst_valid,
  input  logic [`INST_WD-1:0]     i_inst,
  output logic                    o_inst_allowin,
  output logic                    o_commit_valid,
  output logic                    o_commit_gpr_wen,
  output logic [`GPR_ADDR_WD-1:0] o_commit_rd,
  output logic [`XLEN-1:0]        o_commit_gpr_data,
  output logic                    o_commit_csr_wen,
  output logic [`CSR_ADDR_WD-1:0] o_commit_csr_addr,
  output logic [`XLEN-1:0]        o_commit_csr_data
);
  import rv_pipe_pkg::*;

  alu_op_e                 id_alu_op;
  logic                    id_ex_valid, id_gpr_wen, id_csr_wen;
  logic [`GPR_ADDR_WD-1:0] rs1, rs2, id_rd, ex_rd, ex_hazard_rd;
  logic [`XLEN-1:0]        rs1_data, rs2_data, id_opnd_a, id_opnd_b, csr_rdata;
  logic [`CSR_ADDR_WD-1:0] id_csr_addr, ex_csr_addr, csr_raddr;
  logic                    ex_allowin, ex_hazard_valid, ex_wb_valid, wb_allowin;
  logic                    ex_gpr_wen, ex_csr_wen;
  logic [`XLEN-1:0]        ex_gpr_data, ex_csr_data;

  rv_id_stage u_id (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_inst_valid(i_inst_valid), .i_inst(i_inst), .i_ex_allowin(ex_allowin),
    .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
    .i_ex_hazard_valid(ex_hazard_valid), .i_ex_hazard_rd(ex_hazard_rd),
    .o_inst_allowin(o_inst_allowin), .o_rs1(rs1), .o_rs2(rs2),
    .o_ex_valid(id_ex_valid), .o_alu_op(id_alu_op),
    .o_opnd_a(id_opnd_a), .o_opnd_b(id_opnd_b),
    .o_gpr_wen(id_gpr_wen), .o_rd(id_rd),
    .o_csr_wen(id_csr_wen), .o_csr_addr(id_csr_addr)
  );

  rv_ex_stage u_ex (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_valid(id_ex_valid), .i_alu_op(id_alu_op),
    .i_opnd_a(id_opnd_a), .i_opnd_b(id_opnd_b),
    .i_gpr_wen(id_gpr_wen), .i_rd(id_rd),
    .i_csr_wen(id_csr_wen), .i_csr_addr(id_csr_addr),
    .i_wb_allowin(wb_allowin), .i_csr_rdata(csr_rdata),
    .o_allowin(ex_allowin), .o_hazard_valid(ex_hazard_valid),
    .o_hazard_rd(ex_hazard_rd), .o_csr_raddr(csr_raddr), .o_wb_valid(ex_wb_valid),
    .o_gpr_wen(ex_gpr_wen), .o_rd(ex_rd), .o_gpr_data(ex_gpr_data),
    .o_csr_wen(ex_csr_wen), .o_csr_addr(ex_csr_addr), .o_csr_data(ex_csr_data)
  );

  rv_wb_stage u_wb (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_valid(ex_wb_valid),
    .i_gpr_wen(ex_gpr_wen), .i_rd(ex_rd), .i_gpr_data(ex_gpr_data),
    .i_csr_wen(ex_csr_wen), .i_csr_addr(ex_csr_addr), .i_csr_data(ex_csr_data),
    .o_allowin(wb_allowin), .o_commit_valid(o_commit_valid),
    .o_commit_gpr_wen(o_commit_gpr_wen), .o_commit_rd(o_commit_rd),
    .o_commit_gpr_data(o_commit_gpr_data), .o_commit_csr_wen(o_commit_csr_wen),
    .o_commit_csr_addr(o_commit_csr_addr), .o_commit_csr_data(o_commit_csr_data)
  );

  // write ports come straight from the commit signals
  rv_regfile u_rf (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_rs1(rs1), .i_rs2(rs2), .i_csr_raddr(csr_raddr),
    .i_gpr_wen(o_commit_gpr_wen), .i_gpr_waddr(o_commit_rd),
    .i_gpr_wdata(o_commit_gpr_data),
    .i_csr_wen(o_commit_csr_wen), .i_csr_waddr(o_commit_csr_addr),
    .i_csr_wdata(o_commit_csr_data),
    .o_rs1_data(rs1_data), .o_rs2_data(rs2_data), .o_csr_rdata(csr_rdata)
  );

endmodule

/* src/rv_ex_stage.sv */
// execute stage: alu, csr read and hazard report toward decode
`timescale 1ns/1ps
`include "rv_pipe_params.svh"

module rv_ex_stage (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_valid,
  input  rv_pipe_pkg::alu_op_e    i_alu_op,
  input  logic [`XLEN-1:0]        i_opnd_a,
  input  logic [`XLEN-1:0]        i_opnd_b,
  input  logic                    i_gpr_wen,
  input  logic [`GPR_ADDR_WD-1:0] i_rd,
  input  logic                    i_csr_wen,
  input  logic [`CSR_ADDR_WD-1:0] i_csr_addr,
  input  logic                    i_wb_allowin,
  input  logic [`XLEN-1:0]        i_csr_rdata,
  output logic                    o_allowin,
  output logic                    o_hazard_valid,
  output logic [`GPR_ADDR_WD-1:0] o_hazard_rd,
  output logic [`CSR_ADDR_WD-1:0] o_csr_raddr,
  output logic                    o_wb_valid,
  output logic                    o_gpr_wen,
  output logic [`GPR_ADDR_WD-1:0] o_rd,
  output logic [`XLEN-1:0]        o_gpr_data,
  output logic                    o_csr_wen,
  output logic [`CSR_ADDR_WD-1:0] o_csr_addr,
  output logic [`XLEN-1:0]        o_csr_data
);
  import rv_pipe_pkg::*;

  id_to_ex_t ex_in, ex_q;

  assign ex_in = '{alu_op: i_alu_op, opnd_a: i_opnd_a, opnd_b: i_opnd_b,
                   gpr_wen: i_gpr_wen, rd: i_rd, csr_wen: i_csr_wen,
                   csr_addr: i_csr_addr};

  rv_pipe_reg #(.T(id_to_ex_t)) u_ex_reg (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_valid(i_valid), .i_data(ex_in),
    .i_ready_go(1'b1), .i_next_allowin(i_wb_allowin),
    .o_allowin(o_allowin), .o_valid(o_wb_valid), .o_data(ex_q)
  );

  always_comb begin
    case (ex_q.alu_op)
      alu_add:      o_gpr_data = ex_q.opnd_a + ex_q.opnd_b;
      alu_sub:      o_gpr_data = ex_q.opnd_a - ex_q.opnd_b;
      alu_and:      o_gpr_data = ex_q.opnd_a & ex_q.opnd_b;
      alu_or:       o_gpr_data = ex_q.opnd_a | ex_q.opnd_b;
      alu_xor:      o_gpr_data = ex_q.opnd_a ^ ex_q.opnd_b;
      alu_pass_b:   o_gpr_data = ex_q.opnd_b;
      // old csr value goes to rd
      alu_csr_swap: o_gpr_data = i_csr_rdata;
      default:      o_gpr_data = '0;
    endcase
  end

  assign o_csr_raddr    = ex_q.csr_addr;
  assign o_gpr_wen      = ex_q.gpr_wen;
  assign o_rd           = ex_q.rd;
  assign o_csr_wen      = ex_q.csr_wen;
  assign o_csr_addr     = ex_q.csr_addr;
  assign o_csr_data     = ex_q.opnd_a;
  assign o_hazard_valid = o_wb_valid && ex_q.gpr_wen && (ex_q.rd != '0);
  assign o_hazard_rd    = ex_q.rd;

endmodule

/* src/rv_id_stage.sv */
// decode stage: field split, operand select, immediates and raw hazard stall
`timescale 1ns/1ps
`include "rv_pipe_params.svh"

module rv_id_stage (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_inst_valid,
  input  logic [`INST_WD-1:0]     i_inst,
  input  logic                    i_ex_allowin,
  input  logic [`XLEN-1:0]        i_rs1_data,
  input  logic [`XLEN-1:0]        i_rs2_data,
  input  logic                    i_ex_hazard_valid,
  input  logic [`GPR_ADDR_WD-1:0] i_ex_hazard_rd,
  output logic                    o_inst_allowin,
  output logic [`GPR_ADDR_WD-1:0] o_rs1,
  output logic [`GPR_ADDR_WD-1:0] o_rs2,
  output logic                    o_ex_valid,
  output rv_pipe_pkg::alu_op_e    o_alu_op,
  output logic [`XLEN-1:0]        o_opnd_a,
  output logic [`XLEN-1:0]        o_opnd_b,
  output logic                    o_gpr_wen,
  output logic [`GPR_ADDR_WD-1:0] o_rd,
  output logic                    o_csr_wen,
  output logic [`CSR_ADDR_WD-1:0] o_csr_addr
);
  import rv_pipe_pkg::*;

  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_system = 7'b1110011;

  logic [`INST_WD-1:0] inst;
  logic [6:0]          opcode, funct7;
  logic [2:0]          funct3;
  logic [`XLEN-1:0]    imm_i, imm_u;
  logic                uses_rs1, uses_rs2, hazard;

  rv_pipe_reg #(.T(logic [`INST_WD-1:0])) u_id_reg (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_valid(i_inst_valid), .i_data(i_inst),
    .i_ready_go(!hazard), .i_next_allowin(i_ex_allowin),
    .o_allowin(o_inst_allowin), .o_valid(o_ex_valid), .o_data(inst)
  );

  assign opcode     = inst[6:0];
  assign funct3     = inst[14:12];
  assign funct7     = inst[31:25];
  assign o_rd       = inst[11:7];
  assign o_rs1      = inst[19:15];
  assign o_rs2      = inst[24:20];
  assign o_csr_addr = inst[31:20];
  assign imm_i      = {{20{inst[31]}}, inst[31:20]};
  assign imm_u      = {inst[31:12], 12'b0};
  assign o_opnd_a   = i_rs1_data;

  // unsupported encodings fall out with both write enables low
  always_comb begin
    o_alu_op  = alu_add;
    o_opnd_b  = i_rs2_data;
    o_gpr_wen = 1'b0;
    o_csr_wen = 1'b0;
    uses_rs1  = 1'b0;
    uses_rs2  = 1'b0;
    case (opcode)
      opc_op: begin
        o_gpr_wen = 1'b1;
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: o_alu_op = alu_add;
          {7'h20, 3'b000}: o_alu_op = alu_sub;
          {7'h00, 3'b111}: o_alu_op = alu_and;
          {7'h00, 3'b110}: o_alu_op = alu_or;
          {7'h00, 3'b100}: o_alu_op = alu_xor;
          default: begin
            o_gpr_wen = 1'b0;
            uses_rs1  = 1'b0;
            uses_rs2  = 1'b0;
          end
        endcase
      end
      opc_op_imm: begin
        o_gpr_wen = (funct3 == 3'b000);
        uses_rs1  = (funct3 == 3'b000);
        o_opnd_b  = imm_i;
      end
      opc_lui: begin
        o_gpr_wen = 1'b1;
        o_alu_op  = alu_pass_b;
        o_opnd_b  = imm_u;
      end
      opc_system: begin
        // csrrw only
        o_gpr_wen = (funct3 == 3'b001);
        o_csr_wen = (funct3 == 3'b001);
        uses_rs1  = (funct3 == 3'b001);
        o_alu_op  = alu_csr_swap;
      end
      default: ;
    endcase
  end

  // write-back is covered by the regfile bypass, only execute can stall us
  assign hazard = i_ex_hazard_valid &&
                  ((uses_rs1 && (o_rs1 == i_ex_hazard_rd)) ||
                   (uses_rs2 && (o_rs2 == i_ex_hazard_rd)));

endmodule

/* src/rv_pipe_params.svh */
// rv pipeline parameters: data and instruction widths, register counts, csr addresses
`ifndef RV_PIPE_PARAMS_SVH
`define RV_PIPE_PARAMS_SVH

// datapath
`define XLEN        32
`define INST_WD     32

// general purpose registers
`define GPR_ADDR_WD 5
`define GPR_NUM     32

// machine csrs
`define CSR_ADDR_WD 12
`define CSR_MSTATUS 12'h300
`define CSR_MTVEC   12'h305
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342

`endif

/* src/rv_pipe_pkg.sv */
// rv pipeline package: alu operation encoding and stage payload types
`include "rv_pipe_params.svh"

package rv_pipe_pkg;

  typedef enum logic [2:0] {
    alu_add      = 3'd0,
    alu_sub      = 3'd1,
    alu_and      = 3'd2,
    alu_or       = 3'd3,
    alu_xor      = 3'd4,
    // lui passes the upper immediate
    alu_pass_b   = 3'd5,
    alu_csr_swap = 3'd6
  } alu_op_e;

  // decode to execute
  typedef struct packed {
    alu_op_e                 alu_op;
    logic [`XLEN-1:0]        opnd_a;
    logic [`XLEN-1:0]        opnd_b;
    logic                    gpr_wen;
    logic [`GPR_ADDR_WD-1:0] rd;
    logic                    csr_wen;
    logic [`CSR_ADDR_WD-1:0] csr_addr;
  } id_to_ex_t;

  // execute to write back
  typedef struct packed {
    logic                    gpr_wen;
    logic [`GPR_ADDR_WD-1:0] rd;
    logic [`XLEN-1:0]        gpr_data;
    logic                    csr_wen;
    logic [`CSR_ADDR_WD-1:0] csr_addr;
    logic [`XLEN-1:0]        csr_data;
  } ex_to_wb_t;

endpackage

/* src/rv_pipe_reg.sv */
// pipeline stage register: valid flag and typed payload with allowin flow control
`timescale 1ns/1ps

module rv_pipe_reg #(
  parameter type T = logic
) (
  input  logic i_clk,
  input  logic i_rst_n,
  input  logic i_valid,
  input  T     i_data,
  input  logic i_ready_go,
  input  logic i_next_allowin,
  output logic o_allowin,
  output logic o_valid,
  output T     o_data
);

  logic valid_q;
  T     data_q;

  // empty, or the held item moves on this edge
  assign o_allowin = !valid_q || (i_ready_go && i_next_allowin);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
    end else if (o_allowin) begin
      valid_q <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid && o_allowin) begin
      data_q <= i_data;
    end
  end

  // valid toward the next stage
  assign o_valid = valid_q && i_ready_go;
  assign o_data  = data_q;

endmodule

/* src/rv_regfile.sv */
// register file: 32 gprs and four machine csrs, reads bypass same-cycle writes
`timescale 1ns/1ps
`include "rv_pipe_params.svh"

module rv_regfile (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic [`GPR_ADDR_WD-1:0] i_rs1,
  input  logic [`GPR_ADDR_WD-1:0] i_rs2,
  input  logic [`CSR_ADDR_WD-1:0] i_csr_raddr,
  input  logic                    i_gpr_wen,
  input  logic [`GPR_ADDR_WD-1:0] i_gpr_waddr,
  input  logic [`XLEN-1:0]        i_gpr_wdata,
  input  logic                    i_csr_wen,
  input  logic [`CSR_ADDR_WD-1:0] i_csr_waddr,
  input  logic [`XLEN-1:0]        i_csr_wdata,
  output logic [`XLEN-1:0]        o_rs1_data,
  output logic [`XLEN-1:0]        o_rs2_data,
  output logic [`XLEN-1:0]        o_csr_rdata
);

  logic [`XLEN-1:0] gpr_q [`GPR_NUM];
  logic [`XLEN-1:0] csr_q [4];
  logic [2:0]       csr_wsel, csr_rsel;

  // {hit, index} for the implemented csrs
  function automatic logic [2:0] csr_sel(input logic [`CSR_ADDR_WD-1:0] addr);
    case (addr)
      `CSR_MSTATUS: csr_sel = 3'b100;
      `CSR_MTVEC:   csr_sel = 3'b101;
      `CSR_MEPC:    csr_sel = 3'b110;
      `CSR_MCAUSE:  csr_sel = 3'b111;
      default:      csr_sel = 3'b000;
    endcase
  endfunction

  function automatic logic [`XLEN-1:0] gpr_read(input logic [`GPR_ADDR_WD-1:0] addr);
    if (addr == '0) begin
      gpr_read = '0;
    end else if (i_gpr_wen && (i_gpr_waddr == addr)) begin
      gpr_read = i_gpr_wdata;
    end else begin
      gpr_read = gpr_q[addr];
    end
  endfunction

  assign csr_wsel = csr_sel(i_csr_waddr);
  assign csr_rsel = csr_sel(i_csr_raddr);

  // x0 is never written
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `GPR_NUM; i++) begin
        gpr_q[i] <= '0;
      end
    end else if (i_gpr_wen && (i_gpr_waddr != '0)) begin
      gpr_q[i_gpr_waddr] <= i_gpr_wdata;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 4; i++) begin
        csr_q[i] <= '0;
      end
    end else if (i_csr_wen && csr_wsel[2]) begin
      csr_q[csr_wsel[1:0]] <= i_csr_wdata;
    end
  end

  always_comb begin
    o_rs1_data = gpr_read(i_rs1);
    o_rs2_data = gpr_read(i_rs2);
  end

  // unknown csr reads zero
  always_comb begin
    if (!csr_rsel[2]) begin
      o_csr_rdata = '0;
    end else if (i_csr_wen && (i_csr_waddr == i_csr_raddr)) begin
      o_csr_rdata = i_csr_wdata;
    end else begin
      o_csr_rdata = csr_q[csr_rsel[1:0]];
    end
  end

endmodule

/* src/rv_wb_stage.sv */
// write-back stage: holds execute results and drives register file writes and commits
`timescale 1ns/1ps
`include "rv_pipe_params.svh"

module rv_wb_stage (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_valid,
  input  logic                    i_gpr_wen,
  input  logic [`GPR_ADDR_WD-1:0] i_rd,
  input  logic [`XLEN-1:0]        i_gpr_data,
  input  logic                    i_csr_wen,
  input  logic [`CSR_ADDR_WD-1:0] i_csr_addr,
  input  logic [`XLEN-1:0]        i_csr_data,
  output logic                    o_allowin,
  output logic                    o_commit_valid,
  output logic                    o_commit_gpr_wen,
  output logic [`GPR_ADDR_WD-1:0] o_commit_rd,
  output logic [`XLEN-1:0]        o_commit_gpr_data,
  output logic                    o_commit_csr_wen,
  output logic [`CSR_ADDR_WD-1:0] o_commit_csr_addr,
  output logic [`XLEN-1:0]        o_commit_csr_data
);
  import rv_pipe_pkg::*;

  ex_to_wb_t wb_in, wb_q;

  assign wb_in = '{gpr_wen: i_gpr_wen, rd: i_rd, gpr_data: i_gpr_data,
                   csr_wen: i_csr_wen, csr_addr: i_csr_addr, csr_data: i_csr_data};

  // last stage, always drains
  rv_pipe_reg #(.T(ex_to_wb_t)) u_wb_reg (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_valid(i_valid), .i_data(wb_in),
    .i_ready_go(1'b1), .i_next_allowin(1'b1),
    .o_allowin(o_allowin), .o_valid(o_commit_valid), .o_data(wb_q)
  );

  assign o_commit_gpr_wen  = o_commit_valid && wb_q.gpr_wen;
  assign o_commit_rd       = wb_q.rd;
  assign o_commit_gpr_data = wb_q.gpr_data;
  assign o_commit_csr_wen  = o_commit_valid && wb_q.csr_wen;
  assign o_commit_csr_addr = wb_q.csr_addr;
  assign o_commit_csr_data = wb_q.csr_data;

endmodule

/* tb/rv_commit_checker.sv */
// commit checker: in-order reference model of gprs and csrs compared with every commit
`timescale 1ns/1ps
`include "rv_pipe_params.svh"

module rv_commit_checker (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_inst_valid,
  input  logic [`INST_WD-1:0]     i_inst,
  input  logic                    i_inst_allowin,
  input  logic [95:0]             i_name,
  input  logic                    i_has_exp,
  input  logic                    i_exp_gpr_wen,
  input  logic [`GPR_ADDR_WD-1:0] i_exp_rd,
  input  logic [`XLEN-1:0]        i_exp_data,
  input  logic                    i_exp_csr_wen,
  input  logic                    i_commit_valid,
  input  logic                    i_commit_gpr_wen,
  input  logic [`GPR_ADDR_WD-1:0] i_commit_rd,
  input  logic [`XLEN-1:0]        i_commit_gpr_data,
  input  logic                    i_commit_csr_wen,
  input  logic [`CSR_ADDR_WD-1:0] i_commit_csr_addr,
  input  logic [`XLEN-1:0]        i_commit_csr_data,
  output int                      o_errors,
  output int                      o_accepts,
  output int                      o_commits
);

  typedef struct packed {
    logic [95:0]             name;
    logic                    has_exp;
    logic                    exp_gpr_wen;
    logic [`GPR_ADDR_WD-1:0] exp_rd;
    logic [`XLEN-1:0]        exp_data;
    logic                    exp_csr_wen;
    logic                    gpr_wen;
    logic [`GPR_ADDR_WD-1:0] rd;
    logic [`XLEN-1:0]        gpr_data;
    logic                    csr_wen;
    logic [`CSR_ADDR_WD-1:0] csr_addr;
    logic [`XLEN-1:0]        csr_data;
  } entry_t;

  logic [`XLEN-1:0] gpr_m [`GPR_NUM];
  logic [`XLEN-1:0] csr_m [logic [`CSR_ADDR_WD-1:0]];
  entry_t           pending [$];
  entry_t           acc, head;

  function automatic logic csr_known(input logic [`CSR_ADDR_WD-1:0] addr);
    return addr inside {`CSR_MSTATUS, `CSR_MTVEC, `CSR_MEPC, `CSR_MCAUSE};
  endfunction

  // architectural effect of one instruction, applied in accept order
  task automatic predict(input logic [`INST_WD-1:0] inst, output entry_t e);
    logic [`XLEN-1:0]        a, b, imm;
    logic [`CSR_ADDR_WD-1:0] csr;
    a         = gpr_m[inst[19:15]];
    b         = gpr_m[inst[24:20]];
    imm       = {{20{inst[31]}}, inst[31:20]};
    csr       = inst[31:20];
    e         = '0;
    e.rd      = inst[11:7];
    e.gpr_wen = 1'b1;
    case (inst[6:0])
      // r-type, keyed on {funct7, funct3}
      7'h33: begin
        case ({inst[31:25], inst[14:12]})
          10'h000: e.gpr_data = a + b;
          10'h100: e.gpr_data = a - b;
          10'h007: e.gpr_data = a & b;
          10'h006: e.gpr_data = a | b;
          10'h004: e.gpr_data = a ^ b;
          default: e.gpr_wen = 1'b0;
        endcase
      end
      7'h13: begin
        e.gpr_wen  = (inst[14:12] == 3'b000);
        e.gpr_data = a + imm;
      end
      7'h37: e.gpr_data = {inst[31:12], 12'h000};
      // csrrw swaps rs1 into the csr
      7'h73: begin
        e.gpr_wen  = (inst[14:12] == 3'b001);
        e.csr_wen  = e.gpr_wen;
        e.csr_addr = csr;
        e.csr_data = a;
        e.gpr_data = csr_m.exists(csr) ? csr_m[csr] : '0;
      end
      default: e.gpr_wen = 1'b0;
    endcase
    if (e.gpr_wen && (e.rd != '0)) begin
      gpr_m[e.rd] = e.gpr_data;
    end
    if (e.csr_wen && csr_known(csr)) begin
      csr_m[csr] = e.csr_data;
    end
  endtask

  function automatic int field_diff(input logic [95:0] name, input string what,
                                    input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("error %0s %0s expected %h actual %h", name, what, exp, act);
      return 1;
    end
    return 0;
  endfunction

  task automatic compare_commit(input entry_t e);
    int bad;
    bad = field_diff(e.name, "gpr_wen", 32'(e.gpr_wen), 32'(i_commit_gpr_wen));
    bad += field_diff(e.name, "csr_wen", 32'(e.csr_wen), 32'(i_commit_csr_wen));
    if (e.gpr_wen) begin
      bad += field_diff(e.name, "rd", 32'(e.rd), 32'(i_commit_rd));
      bad += field_diff(e.name, "gpr_data", e.gpr_data, i_commit_gpr_data);
    end
    if (e.csr_wen) begin
      bad += field_diff(e.name, "csr_addr", 32'(e.csr_addr), 32'(i_commit_csr_addr));
      bad += field_diff(e.name, "csr_data", e.csr_data, i_commit_csr_data);
    end
    // directed rows also carry their own expected commit
    if (e.has_exp) begin
      bad += field_diff(e.name, "table gpr_wen", 32'(e.exp_gpr_wen), 32'(i_commit_gpr_wen));
      bad += field_diff(e.name, "table csr_wen", 32'(e.exp_csr_wen), 32'(i_commit_csr_wen));
      if (e.exp_gpr_wen) begin
        bad += field_diff(e.name, "table rd", 32'(e.exp_rd), 32'(i_commit_rd));
        bad += field_diff(e.name, "table data", e.exp_data, i_commit_gpr_data);
      end
    end
    if (bad == 0) begin
      $display("ok    %0s", e.name);
    end
    o_errors += bad;
  endtask

  // accepts on the rising edge, inputs are driven on the falling one
  always @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `GPR_NUM; i++) begin
        gpr_m[i] = '0;
      end
      csr_m.delete();
      o_accepts = 0;
    end else if (i_inst_valid && i_inst_allowin) begin
      predict(i_inst, acc);
      acc.name        = i_name;
      acc.has_exp     = i_has_exp;
      acc.exp_gpr_wen = i_exp_gpr_wen;
      acc.exp_rd      = i_exp_rd;
      acc.exp_data    = i_exp_data;
      acc.exp_csr_wen = i_exp_csr_wen;
      pending.push_back(acc);
      o_accepts++;
    end
  end

  // commit ports are stable mid cycle
  always @(negedge i_clk) begin
    if (i_rst_n && i_commit_valid) begin
      o_commits++;
      if (pending.size() == 0) begin
        $display("a commit appeared with no accepted instruction waiting for it");
        o_errors++;
      end else begin
        head = pending.pop_front();
        compare_commit(head);
      end
    end
  end

endmodule

/* tb/tb_rv_core.sv */
// testbench for the rv pipeline tail: directed table, random tail and watchdog
`timescale 1ns/1ps
`include "rv_pipe_params.svh"

module tb_rv_core;

  localparam int num_rows   = 17;
  localparam int num_rand   = 40;
  localparam int clk_period = 20;
  localparam int rst_cycles = 16;

  typedef struct packed {
    logic [95:0]             name;
    logic [`INST_WD-1:0]     inst;
    logic                    gpr_wen;
    logic [`GPR_ADDR_WD-1:0] rd;
    logic [`XLEN-1:0]        data;
    logic                    csr_wen;
  } row_t;

  logic                    i_clk, i_rst_n, i_inst_valid;
  logic [`INST_WD-1:0]     i_inst;
  logic                    o_inst_allowin, o_commit_valid;
  logic                    o_commit_gpr_wen, o_commit_csr_wen;
  logic [`GPR_ADDR_WD-1:0] o_commit_rd;
  logic [`XLEN-1:0]        o_commit_gpr_data, o_commit_csr_data;
  logic [`CSR_ADDR_WD-1:0] o_commit_csr_addr;

  row_t        rows [num_rows];
  row_t        cur;
  logic        cur_has_exp;
  logic [95:0] rand_name;
  logic [31:0] rnd;
  int          row_cnt, stall_cycles, own_errors, chk_errors, accepts, commits;

  rv_core_top uut (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_inst_valid(i_inst_valid), .i_inst(i_inst), .o_inst_allowin(o_inst_allowin),
    .o_commit_valid(o_commit_valid), .o_commit_gpr_wen(o_commit_gpr_wen),
    .o_commit_rd(o_commit_rd), .o_commit_gpr_data(o_commit_gpr_data),
    .o_commit_csr_wen(o_commit_csr_wen), .o_commit_csr_addr(o_commit_csr_addr),
    .o_commit_csr_data(o_commit_csr_data)
  );

  rv_commit_checker u_checker (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_inst_valid(i_inst_valid), .i_inst(i_inst), .i_inst_allowin(o_inst_allowin),
    .i_name(cur.name), .i_has_exp(cur_has_exp), .i_exp_gpr_wen(cur.gpr_wen),
    .i_exp_rd(cur.rd), .i_exp_data(cur.data), .i_exp_csr_wen(cur.csr_wen),
    .i_commit_valid(o_commit_valid), .i_commit_gpr_wen(o_commit_gpr_wen),
    .i_commit_rd(o_commit_rd), .i_commit_gpr_data(o_commit_gpr_data),
    .i_commit_csr_wen(o_commit_csr_wen), .i_commit_csr_addr(o_commit_csr_addr),
    .i_commit_csr_data(o_commit_csr_data),
    .o_errors(chk_errors), .o_accepts(accepts), .o_commits(commits)
  );

  always #(clk_period / 2) i_clk = ~i_clk;

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] enc_csrrw(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] csr);
    return {csr, rs1, 3'b001, rd, 7'b1110011};
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // low registers only, so random ops hit each other often
  function automatic logic [31:0] rand_inst(input logic [31:0] r);
    logic [4:0] rd, rs1, rs2;
    rd  = {1'b0, r[6:3]};
    rs1 = {1'b0, r[10:7]};
    rs2 = {1'b0, r[14:11]};
    case (r[2:0])
      3'd0:    rand_inst = enc_r(7'h00, 3'b000, rd, rs1, rs2);
      3'd1:    rand_inst = enc_r(7'h20, 3'b000, rd, rs1, rs2);
      3'd2:    rand_inst = enc_r(7'h00, 3'b111, rd, rs1, rs2);
      3'd3:    rand_inst = enc_r(7'h00, 3'b110, rd, rs1, rs2);
      3'd4:    rand_inst = enc_r(7'h00, 3'b100, rd, rs1, rs2);
      3'd6:    rand_inst = enc_lui(rd, r[31:12]);
      default: rand_inst = enc_addi(rd, rs1, r[26:15]);
    endcase
  endfunction

  task automatic add_row(input logic [95:0] name, input logic [31:0] inst, input logic wen,
                         input logic [4:0] rd, input logic [31:0] data, input logic csr_wen);
    rows[row_cnt] = '{name, inst, wen, rd, data, csr_wen};
    row_cnt++;
  endtask

  task automatic send_inst(input row_t r, input logic has_exp);
    @(negedge i_clk);
    i_inst_valid = 1'b1;
    i_inst       = r.inst;
    cur          = r;
    cur_has_exp  = has_exp;
    // hold the word while decode is stalled
    while (!o_inst_allowin) begin
      stall_cycles++;
      @(negedge i_clk);
    end
  endtask

  // watchdog
  initial begin
    #((rst_cycles + (num_rows + num_rand) * 8) * clk_period);
    $display("timeout: the pipeline did not commit every instruction in time");
    $display("Done: errors found");
    $finish;
  end

  initial begin
    i_clk        = 1'b0;
    i_rst_n      = 1'b0;
    i_inst_valid = 1'b0;
    i_inst       = '0;
    cur          = '0;
    cur_has_exp  = 1'b0;
    row_cnt      = 0;
    stall_cycles = 0;
    own_errors   = 0;

    add_row("read_x5", enc_r(7'h00, 3'b000, 5'd5, 5'd0, 5'd5), 1'b1, 5'd5, 32'h0, 1'b0);
    add_row("addi_x1", enc_addi(5'd1, 5'd0, 12'd100), 1'b1, 5'd1, 32'h64, 1'b0);
    add_row("addi_neg", enc_addi(5'd2, 5'd0, 12'hff9), 1'b1, 5'd2, 32'hfffffff9, 1'b0);
    add_row("lui_x3", enc_lui(5'd3, 20'h12345), 1'b1, 5'd3, 32'h12345000, 1'b0);
    add_row("add_bypass", enc_r(7'h00, 3'b000, 5'd4, 5'd1, 5'd2), 1'b1, 5'd4, 32'h5d, 1'b0);
    add_row("sub_stall", enc_r(7'h20, 3'b000, 5'd6, 5'd4, 5'd1), 1'b1, 5'd6, 32'hfffffff9, 1'b0);
    add_row("and_stall", enc_r(7'h00, 3'b111, 5'd7, 5'd3, 5'd6), 1'b1, 5'd7, 32'h12345000, 1'b0);
    add_row("or_x8", enc_r(7'h00, 3'b110, 5'd8, 5'd7, 5'd1), 1'b1, 5'd8, 32'h12345064, 1'b0);
    add_row("xor_x9", enc_r(7'h00, 3'b100, 5'd9, 5'd8, 5'd3), 1'b1, 5'd9, 32'h64, 1'b0);
    add_row("write_x0", enc_addi(5'd0, 5'd1, 12'd5), 1'b1, 5'd0, 32'h69, 1'b0);
    add_row("read_x0", enc_r(7'h00, 3'b000, 5'd10, 5'd0, 5'd0), 1'b1, 5'd10, 32'h0, 1'b0);
    add_row("csr_swap1", enc_csrrw(5'd11, 5'd1, 12'h305), 1'b1, 5'd11, 32'h0, 1'b1);
    add_row("csr_swap2", enc_csrrw(5'd12, 5'd3, 12'h305), 1'b1, 5'd12, 32'h64, 1'b1);
    add_row("csr_unknown", enc_csrrw(5'd13, 5'd1, 12'h7c0), 1'b1, 5'd13, 32'h0, 1'b1);
    // lw x5, 0(x1) is not implemented
    add_row("bad_opcode", 32'h0000a283, 1'b0, 5'd0, 32'h0, 1'b0);
    add_row("csr_read3", enc_csrrw(5'd14, 5'd0, 12'h305), 1'b1, 5'd14, 32'h12345000, 1'b1);
    add_row("x5_unchanged", enc_r(7'h00, 3'b000, 5'd15, 5'd5, 5'd0), 1'b1, 5'd15, 32'h0, 1'b0);

    repeat (rst_cycles) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;
    @(negedge i_clk);
    if (o_inst_allowin !== 1'b1 || o_commit_valid !== 1'b0) begin
      $display("error reset expected %b actual %b", 2'b10, {o_inst_allowin, o_commit_valid});
      own_errors++;
    end else begin
      $display("ok    reset");
    end

    for (int r = 0; r < num_rows; r++) begin
      send_inst(rows[r], 1'b1);
    end
    if (stall_cycles == 0) begin
      $display("decode never lowered allowin for the dependent table rows");
      own_errors++;
    end

    rnd = 32'h87c700e4;
    for (int k = 0; k < num_rand; k++) begin
      rnd = xorshift32(rnd);
      $sformat(rand_name, "rand_%0d", k);
      send_inst('{rand_name, rand_inst(rnd), 1'b0, 5'd0, 32'h0, 1'b0}, 1'b0);
    end
    @(negedge i_clk);
    i_inst_valid = 1'b0;

    // drain, then make sure nothing extra comes out
    while (commits < accepts) @(posedge i_clk);
    repeat (4) @(posedge i_clk);
    if (accepts != num_rows + num_rand || commits != accepts) begin
      $display("accepted %0d and committed %0d instructions, expected %0d of each",
               accepts, commits, num_rows + num_rand);
      own_errors++;
    end

    $display("tests %0d, errors %0d", accepts + 1, own_errors + chk_errors);
    if (own_errors + chk_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
